// ==== include/core_ctrl_defines.svh ====
`ifndef CORE_CTRL_DEFINES_SVH
`define CORE_CTRL_DEFINES_SVH

////////////////////////////////////////
// settings bus addresses
////////////////////////////////////////

// spi master, three consecutive slots
`define CORE_SR_SPI_CLKDIV 8'd8
`define CORE_SR_SPI_CFG    8'd9
`define CORE_SR_SPI_DATA   8'd10

// core registers
`define CORE_SR_MISC       8'd16
`define CORE_SR_READBACK   8'd32
`define CORE_SR_GPSDO_ST   8'd40
`define CORE_SR_SYNC       8'd48

////////////////////////////////////////
// readback constants
////////////////////////////////////////
`define CORE_SIGNATURE     32'hACE0BA5E
`define CORE_COMPAT_MAJOR  16'h0010
`define CORE_COMPAT_MINOR  16'h0000

// single radio build
`define CORE_RADIO_ST      8'h01

// spi idle levels and divider width
`define SPI_SEN_IDLE       8'hFF
`define SPI_DIV_W          16

`endif

// ==== hdl/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

   // pps source select, as written to the sync register
   typedef enum logic [1:0] {
      PPS_GPSDO    = 2'd0,
      PPS_EXTERNAL = 2'd1,
      PPS_INTERNAL = 2'd2,
      PPS_OFF      = 2'd3
   } pps_sel_t;

   // readback mux select
   typedef enum logic [1:0] {
      RB_SIGNATURE = 2'd0,
      RB_SPI       = 2'd1,
      RB_STATUS    = 2'd2,
      RB_LOCK      = 2'd3
   } rb_sel_t;

   // spi config word, slave enables in the low byte
   typedef struct packed {
      logic [17:0] rsvd;
      logic [5:0]  bit_count;
      logic [7:0]  sen_sel;
   } spi_cfg_t;

   // sync register word
   typedef struct packed {
      logic [28:0] rsvd;
      logic        time_sync;
      pps_sel_t    pps_select;
   } sync_cfg_t;

   // settings data word, decoded by address
   typedef union packed {
      logic [31:0] word;
      spi_cfg_t    spi_cfg;
      sync_cfg_t   sync_cfg;
   } set_word_u;

endpackage

// ==== hdl/pps_timer.sv ====
module pps_timer
   import core_ctrl_pkg::*;
#(
   parameter int PPS_PERIOD = 100_000_000
)
(
   input  logic     radio_clk,
   input  logic     bus_rst,
   input  logic     i_pps_int,
   input  logic     i_pps_ext,
   input  pps_sel_t i_pps_select,
   input  logic     i_time_sync_cfg,
   output logic     o_pps,
   output logic     o_time_sync
);

   localparam int CNT_W = $clog2(PPS_PERIOD);
   localparam logic [CNT_W-1:0] PPS_LAST = CNT_W'(PPS_PERIOD - 1);

   logic [CNT_W-1:0] pps_cnt;
   logic             pps_gen;
   // bit 0 gpsdo, 1 external, 2 internal, 3 time sync
   logic [3:0]       sync_q1;
   logic [3:0]       sync_q2;

   ////////////////////////////////////////
   // internal pps generator
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         pps_cnt <= '0;
         pps_gen <= 1'b0;
      end else begin
         pps_gen <= (pps_cnt == PPS_LAST);
         if (pps_cnt == PPS_LAST)
            pps_cnt <= '0;
         else
            pps_cnt <= pps_cnt + 1'b1;
      end
   end

   // two flop synchronizer for all sources
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
      end else begin
         sync_q1 <= {i_time_sync_cfg, pps_gen, i_pps_ext, i_pps_int};
         sync_q2 <= sync_q1;
      end
   end

   // source select
   always_comb begin
      case (i_pps_select)
         PPS_GPSDO:    o_pps = sync_q2[0];
         PPS_EXTERNAL: o_pps = sync_q2[1];
         PPS_INTERNAL: o_pps = sync_q2[2];
         default:      o_pps = 1'b0;
      endcase
   end

   assign o_time_sync = sync_q2[3];

endmodule

// ==== hdl/core_settings.sv ====
`include "core_ctrl_defines.svh"

module core_settings
   import core_ctrl_pkg::*;
(
   input  logic        radio_clk,
   input  logic        bus_rst,
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  set_word_u   i_set_data,
   input  logic [31:0] i_spi_readback,
   input  logic [31:0] i_rb_misc,
   input  logic [1:0]  i_lock_signals,
   output logic [31:0] o_misc_outs,
   output pps_sel_t    o_pps_select,
   output logic        o_time_sync_cfg,
   output logic [63:0] o_rb_data
);

   rb_sel_t    rb_sel;
   logic [7:0] gpsdo_st;
   logic [1:0] lock_q1;
   logic [1:0] lock_q2;

   ////////////////////////////////////////
   // setting registers
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         o_misc_outs     <= '0;
         rb_sel          <= RB_SIGNATURE;
         o_pps_select    <= PPS_GPSDO;
         o_time_sync_cfg <= 1'b0;
      end else if (i_set_stb) begin
         if (i_set_addr == `CORE_SR_MISC)
            o_misc_outs <= i_set_data.word;
         if (i_set_addr == `CORE_SR_READBACK)
            rb_sel <= rb_sel_t'(i_set_data.word[1:0]);
         if (i_set_addr == `CORE_SR_SYNC) begin
            o_pps_select    <= i_set_data.sync_cfg.pps_select;
            o_time_sync_cfg <= i_set_data.sync_cfg.time_sync;
         end
      end
   end

   // gpsdo status survives a bus reset
   always_ff @(posedge radio_clk) begin
      if (i_set_stb && i_set_addr == `CORE_SR_GPSDO_ST)
         gpsdo_st <= i_set_data.word[7:0];
   end

   // front-end lock inputs are asynchronous
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         lock_q1 <= '0;
         lock_q2 <= '0;
      end else begin
         lock_q1 <= i_lock_signals;
         lock_q2 <= lock_q1;
      end
   end

   ////////////////////////////////////////
   // readback mux
   ////////////////////////////////////////
   always_comb begin
      case (rb_sel)
         RB_SIGNATURE: o_rb_data = {`CORE_SIGNATURE, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};
         RB_SPI:       o_rb_data = {32'b0, i_spi_readback};
         RB_STATUS:    o_rb_data = {16'b0, `CORE_RADIO_ST, gpsdo_st, i_rb_misc};
         default:      o_rb_data = {62'b0, lock_q2};
      endcase
   end

endmodule

// ==== hdl/spi_fsm.sv ====
`include "core_ctrl_defines.svh"

module spi_fsm
   import core_ctrl_pkg::*;
(
   input  logic       radio_clk,
   input  logic       bus_rst,
   input  logic       i_set_stb,
   input  logic [7:0] i_set_addr,
   input  set_word_u  i_set_data,
   input  logic       i_tick,
   input  logic       i_last_bit,
   output logic       o_start,
   output logic       o_run,
   output logic       o_load,
   output logic       o_shift_out,
   output logic       o_capture,
   output logic       o_sclk,
   output logic [7:0] o_sen,
   output logic [5:0] o_bit_count,
   output logic       o_spi_ready
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_SETUP = 2'd1;
   localparam logic [1:0] ST_RISE  = 2'd2;
   localparam logic [1:0] ST_FALL  = 2'd3;

   logic [1:0] state;
   logic [1:0] state_nxt;
   logic [7:0] sen_sel;
   logic       go;

   // config register, spi_cfg view of the word
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         sen_sel     <= '0;
         o_bit_count <= '0;
      end else if (i_set_stb && i_set_addr == `CORE_SR_SPI_CFG) begin
         sen_sel     <= i_set_data.spi_cfg.sen_sel;
         o_bit_count <= i_set_data.spi_cfg.bit_count;
      end
   end

   // data writes while busy are dropped
   assign go = i_set_stb && (i_set_addr == `CORE_SR_SPI_DATA) && (state == ST_IDLE);

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:  if (go) state_nxt = ST_SETUP;
         ST_SETUP: if (i_tick) state_nxt = ST_RISE;
         ST_RISE:  if (i_tick) state_nxt = ST_FALL;
         default:  if (i_tick) state_nxt = i_last_bit ? ST_IDLE : ST_RISE;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (bus_rst)
         state <= ST_IDLE;
      else
         state <= state_nxt;
   end

   ////////////////////////////////////////
   // controls to timer and shifter
   ////////////////////////////////////////
   assign o_start     = go;
   assign o_load      = go;
   assign o_run       = (state != ST_IDLE);
   // miso sampled on entry to rise
   assign o_capture   = i_tick && ((state == ST_SETUP) || (state == ST_FALL && !i_last_bit));
   // mosi advances on entry to fall
   assign o_shift_out = i_tick && (state == ST_RISE);

   assign o_sclk      = (state == ST_RISE);
   assign o_sen       = (state == ST_IDLE) ? `SPI_SEN_IDLE : ~sen_sel;
   assign o_spi_ready = (state == ST_IDLE);

endmodule

// ==== hdl/spi_timer.sv ====
`include "core_ctrl_defines.svh"

module spi_timer
   import core_ctrl_pkg::*;
(
   input  logic       radio_clk,
   input  logic       bus_rst,
   input  logic       i_set_stb,
   input  logic [7:0] i_set_addr,
   input  set_word_u  i_set_data,
   input  logic       i_start,
   input  logic       i_run,
   input  logic       i_shift_out,
   input  logic [5:0] i_bit_count,
   output logic       o_tick,
   output logic       o_last_bit
);

   logic [`SPI_DIV_W-1:0] clkdiv;
   logic [`SPI_DIV_W-1:0] half_cnt;
   logic [5:0]            bit_cnt;

   // divider setting, half period is clkdiv+1 cycles
   always_ff @(posedge radio_clk) begin
      if (bus_rst)
         clkdiv <= '0;
      else if (i_set_stb && i_set_addr == `CORE_SR_SPI_CLKDIV)
         clkdiv <= i_set_data.word[`SPI_DIV_W-1:0];
   end

   assign o_tick = i_run && (half_cnt == clkdiv);

   always_ff @(posedge radio_clk) begin
      if (bus_rst || i_start || !i_run || o_tick)
         half_cnt <= '0;
      else
         half_cnt <= half_cnt + 1'b1;
   end

   // bits left, counted down on each falling edge
   always_ff @(posedge radio_clk) begin
      if (bus_rst)
         bit_cnt <= '0;
      else if (i_start)
         bit_cnt <= i_bit_count;
      else if (i_shift_out)
         bit_cnt <= bit_cnt - 6'd1;
   end

   assign o_last_bit = (bit_cnt == 6'd0);

endmodule

// ==== hdl/spi_shifter.sv ====
module spi_shifter
   import core_ctrl_pkg::*;
(
   input  logic        radio_clk,
   input  logic        bus_rst,
   input  set_word_u   i_set_data,
   input  logic [5:0]  i_bit_count,
   input  logic        i_load,
   input  logic        i_shift_out,
   input  logic        i_capture,
   input  logic        i_miso,
   output logic        o_mosi,
   output logic [31:0] o_readback
);

   logic [31:0] tx_reg;
   logic [5:0]  align_sh;

   // msb first, so push the used bits to the top
   assign align_sh = 6'd32 - i_bit_count;

   always_ff @(posedge radio_clk) begin
      if (bus_rst)
         tx_reg <= '0;
      else if (i_load)
         tx_reg <= i_set_data.word << align_sh;
      else if (i_shift_out)
         tx_reg <= {tx_reg[30:0], 1'b0};
   end

   assign o_mosi = tx_reg[31];

   // received bits enter at the low end
   always_ff @(posedge radio_clk) begin
      if (bus_rst || i_load)
         o_readback <= '0;
      else if (i_capture)
         o_readback <= {o_readback[30:0], i_miso};
   end

endmodule

// ==== hdl/core_ctrl.sv ====
module core_ctrl
   import core_ctrl_pkg::*;
#(
   parameter int PPS_PERIOD = 100_000_000
)
(
   input  logic        radio_clk,
   input  logic        bus_rst,
   input  logic        i_set_stb,
   input  logic [7:0]  i_set_addr,
   input  set_word_u   i_set_data,
   input  logic        i_pps_int,
   input  logic        i_pps_ext,
   input  logic        i_miso,
   input  logic [31:0] i_rb_misc,
   input  logic [1:0]  i_lock_signals,
   output logic        o_pps,
   output logic        o_time_sync,
   output logic [7:0]  o_sen,
   output logic        o_sclk,
   output logic        o_mosi,
   output logic        o_spi_ready,
   output logic [31:0] o_misc_outs,
   output logic [63:0] o_rb_data
);

   pps_sel_t    pps_select;
   logic        time_sync_cfg;
   logic [31:0] spi_readback;
   logic        spi_tick;
   logic        spi_last_bit;
   logic        spi_start;
   logic        spi_run;
   logic        spi_load;
   logic        spi_shift_out;
   logic        spi_capture;
   logic [5:0]  spi_bit_count;

   ////////////////////////////////////////
   // registers and readback
   ////////////////////////////////////////
   core_settings settings_i (
      .radio_clk(radio_clk), .bus_rst(bus_rst),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_spi_readback(spi_readback), .i_rb_misc(i_rb_misc),
      .i_lock_signals(i_lock_signals),
      .o_misc_outs(o_misc_outs), .o_pps_select(pps_select),
      .o_time_sync_cfg(time_sync_cfg), .o_rb_data(o_rb_data)
   );

   pps_timer #(.PPS_PERIOD(PPS_PERIOD)) pps_i (
      .radio_clk(radio_clk), .bus_rst(bus_rst),
      .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext),
      .i_pps_select(pps_select), .i_time_sync_cfg(time_sync_cfg),
      .o_pps(o_pps), .o_time_sync(o_time_sync)
   );

   ////////////////////////////////////////
   // spi master
   ////////////////////////////////////////
   spi_fsm spi_fsm_i (
      .radio_clk(radio_clk), .bus_rst(bus_rst),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_tick(spi_tick), .i_last_bit(spi_last_bit),
      .o_start(spi_start), .o_run(spi_run), .o_load(spi_load),
      .o_shift_out(spi_shift_out), .o_capture(spi_capture),
      .o_sclk(o_sclk), .o_sen(o_sen), .o_bit_count(spi_bit_count),
      .o_spi_ready(o_spi_ready)
   );

   spi_timer spi_timer_i (
      .radio_clk(radio_clk), .bus_rst(bus_rst),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_start(spi_start), .i_run(spi_run), .i_shift_out(spi_shift_out),
      .i_bit_count(spi_bit_count),
      .o_tick(spi_tick), .o_last_bit(spi_last_bit)
   );

   spi_shifter spi_shifter_i (
      .radio_clk(radio_clk), .bus_rst(bus_rst),
      .i_set_data(i_set_data), .i_bit_count(spi_bit_count),
      .i_load(spi_load), .i_shift_out(spi_shift_out), .i_capture(spi_capture),
      .i_miso(i_miso),
      .o_mosi(o_mosi), .o_readback(spi_readback)
   );

endmodule

// ==== testbench/core_ctrl_chk.sv ====
`include "core_ctrl_defines.svh"

module core_ctrl_chk
   import core_ctrl_pkg::*;
(
   input logic       radio_clk,
   input logic       bus_rst,
   input logic       i_set_stb,
   input logic [7:0] i_set_addr,
   input set_word_u  i_set_data,
   input logic       i_pps,
   input logic [7:0] i_sen,
   input logic       i_sclk,
   input logic       i_spi_ready
);

   logic sync_wr;
   logic off_wr;

   // bus writes to the sync register
   assign sync_wr = i_set_stb && (i_set_addr == `CORE_SR_SYNC);
   assign off_wr  = sync_wr && (i_set_data.sync_cfg.pps_select == PPS_OFF);

   ////////////////////////////////////////
   // spi idle levels
   ////////////////////////////////////////
   sen_idle_a: assert property (@(posedge radio_clk) disable iff (bus_rst)
      i_spi_ready |-> (i_sen == `SPI_SEN_IDLE))
      else $error("slave enable active while the SPI master is idle");

   sclk_idle_a: assert property (@(posedge radio_clk) disable iff (bus_rst)
      i_spi_ready |-> !i_sclk)
      else $error("sclk high while the SPI master is idle");

   // pps blocked two cycles after the select is written off
   pps_off_a: assert property (@(posedge radio_clk) disable iff (bus_rst)
      ($past(off_wr, 2) && !$past(sync_wr, 1)) |-> !i_pps)
      else $error("pps pulse seen with the select off");

endmodule

bind core_ctrl core_ctrl_chk chk_i (
   .radio_clk(radio_clk),
   .bus_rst(bus_rst),
   .i_set_stb(i_set_stb),
   .i_set_addr(i_set_addr),
   .i_set_data(i_set_data),
   .i_pps(o_pps),
   .i_sen(o_sen),
   .i_sclk(o_sclk),
   .i_spi_ready(o_spi_ready)
);

// ==== testbench/core_ctrl_tb.sv ====
`include "core_ctrl_defines.svh"

module core_ctrl_tb
   import core_ctrl_pkg::*;
();

   localparam int PPS_PERIOD  = 16;
   localparam int SPI_TIMEOUT = 2000;

   typedef enum logic [1:0] {K_WRITE, K_SPI, K_PPS, K_LOCK} kind_t;

   typedef struct packed {
      kind_t       kind;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [31:0] cfg;
      logic [15:0] div;
      logic [31:0] window;
      logic [31:0] exp_word;
      logic [63:0] exp_rb;
   } test_entry_t;

   logic        radio_clk;
   logic        bus_rst;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   set_word_u   i_set_data;
   logic        i_pps_int;
   logic        i_pps_ext;
   logic        i_miso;
   logic [31:0] i_rb_misc;
   logic [1:0]  i_lock_signals;
   logic        o_pps;
   logic        o_time_sync;
   logic [7:0]  o_sen;
   logic        o_sclk;
   logic        o_mosi;
   logic        o_spi_ready;
   logic [31:0] o_misc_outs;
   logic [63:0] o_rb_data;

   test_entry_t tbl[$];
   logic [31:0] rng;
   int          errors;
   bit          spi_hung;

   // spi loopback
   assign i_miso = o_mosi;

   core_ctrl #(.PPS_PERIOD(PPS_PERIOD)) dut_i (
      .radio_clk(radio_clk), .bus_rst(bus_rst),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .i_pps_int(i_pps_int), .i_pps_ext(i_pps_ext), .i_miso(i_miso),
      .i_rb_misc(i_rb_misc), .i_lock_signals(i_lock_signals),
      .o_pps(o_pps), .o_time_sync(o_time_sync), .o_sen(o_sen), .o_sclk(o_sclk),
      .o_mosi(o_mosi), .o_spi_ready(o_spi_ready), .o_misc_outs(o_misc_outs),
      .o_rb_data(o_rb_data)
   );

   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] sync_word(input pps_sel_t sel, input logic ts);
      set_word_u w;
      w.word = '0;
      w.sync_cfg.pps_select = sel;
      w.sync_cfg.time_sync  = ts;
      return w.word;
   endfunction

   function automatic logic [31:0] spi_cfg_word(input logic [5:0] bc, input logic [7:0] sel);
      set_word_u w;
      w.word = '0;
      w.spi_cfg.bit_count = bc;
      w.spi_cfg.sen_sel   = sel;
      return w.word;
   endfunction

   function automatic test_entry_t make_entry(input kind_t kind, input logic [7:0] addr,
         input logic [31:0] data, input logic [31:0] cfg, input logic [15:0] div,
         input logic [31:0] window, input logic [31:0] exp_word, input logic [63:0] exp_rb);
      test_entry_t e;
      e.kind     = kind;
      e.addr     = addr;
      e.data     = data;
      e.cfg      = cfg;
      e.div      = div;
      e.window   = window;
      e.exp_word = exp_word;
      e.exp_rb   = exp_rb;
      return e;
   endfunction

   // inputs move 5 units after the rising edge
   task automatic step(input int n);
      repeat (n) @(posedge radio_clk);
      #5;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      i_set_stb       = 1'b1;
      i_set_addr      = addr;
      i_set_data.word = data;
      step(1);
      i_set_stb = 1'b0;
   endtask

   task automatic check_rb(input logic [63:0] got, input logic [63:0] exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_pps(input pps_sel_t sel, input int got, input int exp);
      if (got != exp) begin
         $display("Mismatch at %0t: o_pps pulses with select %s got %0d expected %0d",
                  $time, sel.name(), got, exp);
         errors++;
      end
   endtask

   ////////////////////////////////////////
   // one task per entry kind
   ////////////////////////////////////////
   task automatic run_write(input test_entry_t e);
      bus_write(e.addr, e.data);
      step(1);
      check_word(o_misc_outs, e.exp_word, "o_misc_outs");
      check_rb(o_rb_data, e.exp_rb, "o_rb_data");
   endtask

   task automatic run_spi(input test_entry_t e);
      logic [7:0] sen_exp;
      logic [7:0] sen_seen;
      logic       prev_sclk;
      int         rises;
      int         cycles;
      sen_exp   = ~e.cfg[7:0];
      sen_seen  = sen_exp;
      prev_sclk = 1'b0;
      rises     = 0;
      cycles    = 0;
      bus_write(`CORE_SR_SPI_CLKDIV, {16'b0, e.div});
      bus_write(`CORE_SR_SPI_CFG, e.cfg);
      bus_write(`CORE_SR_READBACK, 32'(RB_SPI));
      bus_write(e.addr, e.data);
      if (o_spi_ready) begin
         $display("Error at %0t: the SPI transfer did not start", $time);
         errors++;
      end
      // second data word while busy, must be dropped
      i_set_stb       = 1'b1;
      i_set_addr      = e.addr;
      i_set_data.word = ~e.data;
      while (!o_spi_ready && cycles < SPI_TIMEOUT) begin
         if (o_sclk && !prev_sclk)
            rises++;
         prev_sclk = o_sclk;
         if (o_sen !== sen_exp && sen_seen === sen_exp)
            sen_seen = o_sen;
         step(1);
         i_set_stb = 1'b0;
         cycles++;
      end
      i_set_stb = 1'b0;
      if (!o_spi_ready) begin
         $display("Error at %0t: o_spi_ready stayed low for %0d cycles", $time, SPI_TIMEOUT);
         errors++;
         spi_hung = 1'b1;
      end else begin
         check_word(32'(rises), e.exp_word, "o_sclk rises");
         check_word({24'b0, sen_seen}, {24'b0, sen_exp}, "o_sen during transfer");
         check_rb(o_rb_data, e.exp_rb, "spi readback");
      end
   endtask

   task automatic run_pps(input test_entry_t e);
      pps_sel_t sel;
      int       pulses;
      int       i;
      sel    = pps_sel_t'(e.data[1:0]);
      pulses = 0;
      bus_write(e.addr, e.data);
      step(3);
      // internal source needs no input pulse
      if (sel != PPS_INTERNAL) begin
         i_pps_ext = 1'b1;
         i_pps_int = (sel == PPS_OFF);
      end
      step(1);
      i_pps_ext = 1'b0;
      i_pps_int = 1'b0;
      for (i = 0; i < int'(e.window); i++) begin
         if (o_pps)
            pulses++;
         step(1);
      end
      check_pps(sel, pulses, int'(e.exp_word));
   endtask

   task automatic run_lock(input test_entry_t e);
      i_lock_signals = e.cfg[1:0];
      bus_write(`CORE_SR_READBACK, 32'(RB_LOCK));
      bus_write(e.addr, e.data);
      step(3);
      check_rb(o_rb_data, e.exp_rb, "lock readback");
      check_word({31'b0, o_time_sync}, e.exp_word, "o_time_sync");
   endtask

   ////////////////////////////////////////
   // stimulus table
   ////////////////////////////////////////
   task automatic build_table();
      logic [31:0] misc_val;
      logic [31:0] gps_val;
      logic [31:0] spi_data;
      logic [31:0] bc;
      logic [7:0]  sel;
      logic [15:0] div;
      logic [63:0] sig_rb;
      logic [63:0] status_rb;
      logic [31:0] mask;
      int          n;
      sig_rb = {`CORE_SIGNATURE, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};
      rng = xorshift32(rng);
      misc_val = rng;
      rng = xorshift32(rng);
      gps_val = rng;
      status_rb = {16'b0, `CORE_RADIO_ST, gps_val[7:0], i_rb_misc};
      tbl.push_back(make_entry(K_WRITE, `CORE_SR_MISC, misc_val, 32'd0, 16'd0, 32'd0,
                               misc_val, sig_rb));
      tbl.push_back(make_entry(K_WRITE, `CORE_SR_GPSDO_ST, gps_val, 32'd0, 16'd0, 32'd0,
                               misc_val, sig_rb));
      tbl.push_back(make_entry(K_WRITE, `CORE_SR_READBACK, 32'(RB_STATUS), 32'd0, 16'd0,
                               32'd0, misc_val, status_rb));
      rng = xorshift32(rng);
      // address 77 has no owner
      tbl.push_back(make_entry(K_WRITE, 8'd77, rng, 32'd0, 16'd0, 32'd0, misc_val, status_rb));
      for (n = 0; n < 3; n++) begin
         rng = xorshift32(rng);
         spi_data = rng;
         rng = xorshift32(rng);
         bc  = (rng % 32) + 32'd1;
         sel = rng[15:8];
         div = {14'b0, rng[17:16]};
         mask = (bc == 32'd32) ? 32'hFFFF_FFFF : ((32'd1 << bc) - 32'd1);
         tbl.push_back(make_entry(K_SPI, `CORE_SR_SPI_DATA, spi_data,
                                  spi_cfg_word(bc[5:0], sel), div, 32'd0, bc,
                                  {32'b0, spi_data & mask}));
      end
      tbl.push_back(make_entry(K_PPS, `CORE_SR_SYNC, sync_word(PPS_EXTERNAL, 1'b0), 32'd0,
                               16'd0, 32'd4, 32'd1, 64'd0));
      tbl.push_back(make_entry(K_PPS, `CORE_SR_SYNC, sync_word(PPS_INTERNAL, 1'b0), 32'd0,
                               16'd0, 32'd64, 32'(64 / PPS_PERIOD), 64'd0));
      tbl.push_back(make_entry(K_PPS, `CORE_SR_SYNC, sync_word(PPS_OFF, 1'b0), 32'd0,
                               16'd0, 32'd16, 32'd0, 64'd0));
      tbl.push_back(make_entry(K_LOCK, `CORE_SR_SYNC, sync_word(PPS_OFF, 1'b1), 32'd2,
                               16'd0, 32'd0, 32'd1, {62'b0, 2'b10}));
      tbl.push_back(make_entry(K_LOCK, `CORE_SR_SYNC, sync_word(PPS_OFF, 1'b0), 32'd1,
                               16'd0, 32'd0, 32'd0, {62'b0, 2'b01}));
   endtask

   initial begin
      int    idx;
      int    err_before;
      int    failed;
      kind_t kind;
      errors          = 0;
      failed          = 0;
      spi_hung        = 1'b0;
      rng             = 32'h1847e5dd;
      bus_rst         = 1'b1;
      i_set_stb       = 1'b0;
      i_set_addr      = '0;
      i_set_data.word = '0;
      i_pps_int       = 1'b0;
      i_pps_ext       = 1'b0;
      i_lock_signals  = '0;
      rng             = xorshift32(rng);
      i_rb_misc       = rng;
      build_table();
      step(2);
      bus_rst = 1'b0;

      // reset state
      check_rb(o_rb_data, {`CORE_SIGNATURE, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR},
               "o_rb_data after reset");
      check_word(o_misc_outs, 32'd0, "o_misc_outs after reset");
      check_word({31'b0, o_spi_ready}, 32'd1, "o_spi_ready after reset");
      check_word({24'b0, o_sen}, {24'b0, `SPI_SEN_IDLE}, "o_sen after reset");
      check_word({31'b0, o_sclk}, 32'd0, "o_sclk after reset");
      check_word({31'b0, o_mosi}, 32'd0, "o_mosi after reset");
      if (errors != 0)
         failed++;
      $display("test 0 reset: %s", (errors == 0) ? "ok" : "FAILED");

      idx = 0;
      while (idx < tbl.size() && !spi_hung) begin
         err_before = errors;
         kind = tbl[idx].kind;
         case (kind)
            K_WRITE: run_write(tbl[idx]);
            K_SPI:   run_spi(tbl[idx]);
            K_PPS:   run_pps(tbl[idx]);
            default: run_lock(tbl[idx]);
         endcase
         if (errors != err_before)
            failed++;
         $display("test %0d %s: %s", idx + 1, kind.name(),
                  (errors == err_before) ? "ok" : "FAILED");
         idx++;
      end

      $display("tests run %0d, failed %0d, errors %0d", idx + 1, failed, errors);
      if (errors == 0 && !spi_hung) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== core_ctrl.f ====
+incdir+include
hdl/core_ctrl_pkg.sv
hdl/pps_timer.sv
hdl/core_settings.sv
hdl/spi_fsm.sv
hdl/spi_timer.sv
hdl/spi_shifter.sv
hdl/core_ctrl.sv
testbench/core_ctrl_chk.sv
testbench/core_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core_ctrl testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module core_ctrl_tb \
   -f core_ctrl.f -o core_ctrl_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/core_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Verification passed" "$LOG"; then
   exit 0
fi
exit 1
